//--- rtl/xgpon_pkg.sv
package xgpon_pkg;

    ////////////////////
    // line and buffer sizes
    ////////////////////
    localparam int DATA_W          = 32;
    localparam int KEEP_W          = DATA_W / 8;
    localparam int FIFO_DEPTH      = 64;
    localparam int DESC_DEPTH      = 4;
    localparam int WORD_AW         = $clog2(FIFO_DEPTH);
    localparam int DESC_AW         = $clog2(DESC_DEPTH);
    localparam int MAX_FRAME_WORDS = 32;
    localparam int LEN_W           = $clog2(MAX_FRAME_WORDS + 1);  // holds 0..MAX

    ////////////////////
    // burst format
    ////////////////////
    localparam int              PREAMBLE_WORDS   = 4;
    localparam logic [DATA_W-1:0] PREAMBLE_PATTERN = 32'hAAAA_AAAA;  // 1010...
    localparam logic [DATA_W-1:0] SYNC_WORD        = 32'h0556_0556;
    localparam int              SYNC_THRESHOLD   = 5;   // max bit errors on sync
    localparam int              GUARD_WORDS      = 2;
    localparam logic [7:0]      HDR_MAGIC        = 8'hA5;

    // ethernet stream word
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
    } eth_word_t;

    // pon line word, burst_en high inside a burst only
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              burst_en;
    } pon_word_t;

    typedef struct packed {
        logic [LEN_W-1:0]  len;   // words
        logic [KEEP_W-1:0] keep;  // keep of last word
    } frame_desc_t;

    // header word sent right after sync
    typedef struct packed {
        logic [7:0]        magic;
        logic [7:0]        seq;
        logic [KEEP_W-1:0] keep;
        logic [11:0]       len;
    } pon_hdr_t;

    typedef enum logic [2:0] {
        BT_IDLE,
        BT_PREAMBLE,
        BT_SYNC,
        BT_HEADER,
        BT_PAYLOAD,
        BT_GUARD
    } burst_state_e;

    typedef enum logic [1:0] {
        FS_HUNT,
        FS_HEADER,
        FS_PAYLOAD
    } sync_state_e;

endpackage

//--- rtl/eth_ingress.sv
`timescale 1ns/10ps

module eth_ingress import xgpon_pkg::*; (
    input  logic        axis_clk,
    input  logic        rst,

    input  eth_word_t   eth_in,
    input  logic        eth_in_valid,
    output logic        eth_in_ready,

    output eth_word_t   wr_word,
    output logic        wr_en,
    output logic        wr_commit,
    output logic        wr_abort,
    output frame_desc_t wr_desc,
    input  logic        wr_space
);

    logic [LEN_W-1:0] word_cnt;  // words of current frame already written
    logic             discard;   // swallowing rest of an oversize frame
    logic             xfer;
    logic             too_long;

    ////////////////////
    // handshake
    ////////////////////
    // while discarding nothing is stored, so never stall the source
    assign eth_in_ready = discard | wr_space;
    assign xfer         = eth_in_valid & eth_in_ready;

    // word number MAX+1 arrives, frame is dropped
    assign too_long = xfer & ~discard & (word_cnt == LEN_W'(MAX_FRAME_WORDS));

    ////////////////////
    // fifo write side
    ////////////////////
    assign wr_word   = eth_in;
    assign wr_en     = xfer & ~discard & ~too_long;
    assign wr_abort  = too_long;               // one pulse per bad frame
    assign wr_commit = wr_en & eth_in.last;

    assign wr_desc.len  = word_cnt + 1'b1;     // count includes this word
    assign wr_desc.keep = eth_in.keep;

    always_ff @(posedge axis_clk) begin
        if (rst) begin
            word_cnt <= '0;
            discard  <= 1'b0;
        end else if (xfer) begin
            if (eth_in.last) begin
                // end of frame, good or dropped
                word_cnt <= '0;
                discard  <= 1'b0;
            end else if (too_long) begin
                word_cnt <= '0;
                discard  <= 1'b1;
            end else if (!discard) begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

endmodule

//--- rtl/frame_fifo.sv
`timescale 1ns/10ps

module frame_fifo import xgpon_pkg::*; (
    input  logic        axis_clk,
    input  logic        rst,

    // write side, from ingress
    input  eth_word_t   wr_word,
    input  logic        wr_en,
    input  logic        wr_commit,
    input  logic        wr_abort,
    input  frame_desc_t wr_desc,
    output logic        wr_space,

    // read side, to burst builder
    output logic        rd_desc_valid,
    output frame_desc_t rd_desc,
    input  logic        rd_desc_pop,
    input  logic        rd_en,
    output eth_word_t   rd_word
);

    eth_word_t   mem      [FIFO_DEPTH];
    frame_desc_t desc_mem [DESC_DEPTH];

    // extra msb on every pointer for full/empty
    logic [WORD_AW:0] wr_ptr;
    logic [WORD_AW:0] start_ptr;   // first word of frame being written
    logic [WORD_AW:0] rd_ptr;
    logic [DESC_AW:0] dwr_ptr;
    logic [DESC_AW:0] drd_ptr;

    logic [WORD_AW:0] words_used;  // includes uncommitted words
    logic [DESC_AW:0] descs_used;

    ////////////////////
    // occupancy
    ////////////////////
    assign words_used = wr_ptr - rd_ptr;
    assign descs_used = dwr_ptr - drd_ptr;

    // room for one more word and for its frame descriptor
    assign wr_space = (words_used < (WORD_AW + 1)'(FIFO_DEPTH)) &&
                      (descs_used < (DESC_AW + 1)'(DESC_DEPTH));

    ////////////////////
    // storage
    ////////////////////
    always_ff @(posedge axis_clk) begin
        if (wr_en) begin
            mem[wr_ptr[WORD_AW-1:0]] <= wr_word;
        end
        if (wr_commit) begin
            desc_mem[dwr_ptr[DESC_AW-1:0]] <= wr_desc;
        end
    end

    ////////////////////
    // pointers
    ////////////////////
    always_ff @(posedge axis_clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            start_ptr <= '0;
            rd_ptr    <= '0;
            dwr_ptr   <= '0;
            drd_ptr   <= '0;
        end else begin
            // abort never comes with a write, rewind drops the partial frame
            if (wr_abort) begin
                wr_ptr <= start_ptr;
            end else if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            // commit rides on the last word, next frame starts after it
            if (wr_commit) begin
                start_ptr <= wr_ptr + 1'b1;
                dwr_ptr   <= dwr_ptr + 1'b1;
            end

            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (rd_desc_pop) begin
                drd_ptr <= drd_ptr + 1'b1;
            end
        end
    end

    ////////////////////
    // read side
    ////////////////////
    // committed frames only, visible the cycle after commit
    assign rd_desc_valid = (dwr_ptr != drd_ptr);
    assign rd_desc       = desc_mem[drd_ptr[DESC_AW-1:0]];
    assign rd_word       = mem[rd_ptr[WORD_AW-1:0]];  // async read, same cycle

endmodule

//--- rtl/burst_tx.sv
`timescale 1ns/10ps

module burst_tx import xgpon_pkg::*; (
    input  logic        axis_clk,
    input  logic        rst,

    input  logic        rd_desc_valid,
    input  frame_desc_t rd_desc,
    output logic        rd_desc_pop,
    output logic        rd_en,
    input  eth_word_t   rd_word,

    output pon_word_t   pon_tx
);

    burst_state_e     state;
    logic [LEN_W-1:0] cnt;    // word counter within current section
    frame_desc_t      cur;    // frame being sent
    logic [7:0]       seq;    // burst sequence number
    pon_hdr_t         hdr;

    // header word for the current frame
    assign hdr.magic = HDR_MAGIC;
    assign hdr.seq   = seq;
    assign hdr.keep  = cur.keep;
    assign hdr.len   = 12'(cur.len);

    ////////////////////
    // fifo handshake
    ////////////////////
    assign rd_desc_pop = (state == BT_IDLE) & rd_desc_valid;
    assign rd_en       = (state == BT_PAYLOAD);  // one word per payload cycle

    // line word follows the state directly
    always_comb begin
        pon_tx.data     = '0;
        pon_tx.burst_en = 1'b1;
        case (state)
            BT_PREAMBLE: pon_tx.data = PREAMBLE_PATTERN;
            BT_SYNC:     pon_tx.data = SYNC_WORD;
            BT_HEADER:   pon_tx.data = hdr;
            BT_PAYLOAD:  pon_tx.data = rd_word.data;
            default:     pon_tx.burst_en = 1'b0;  // idle and guard
        endcase
    end

    // descriptor kept for the whole burst
    always_ff @(posedge axis_clk) begin
        if (rd_desc_pop) begin
            cur <= rd_desc;
        end
    end

    ////////////////////
    // burst fsm
    ////////////////////
    always_ff @(posedge axis_clk) begin
        if (rst) begin
            state <= BT_IDLE;
            cnt   <= '0;
            seq   <= '0;
        end else begin
            case (state)
                BT_IDLE: begin
                    cnt <= '0;
                    if (rd_desc_valid) begin
                        state <= BT_PREAMBLE;
                    end
                end
                BT_PREAMBLE: begin
                    if (cnt == LEN_W'(PREAMBLE_WORDS - 1)) begin
                        cnt   <= '0;
                        state <= BT_SYNC;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                BT_SYNC: state <= BT_HEADER;
                BT_HEADER: begin
                    seq   <= seq + 1'b1;  // wraps at 8 bits
                    state <= BT_PAYLOAD;
                end
                BT_PAYLOAD: begin
                    if (cnt == cur.len - 1'b1) begin
                        cnt   <= '0;
                        state <= BT_GUARD;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                BT_GUARD: begin
                    if (cnt == LEN_W'(GUARD_WORDS - 1)) begin
                        cnt   <= '0;
                        state <= BT_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= BT_IDLE;
            endcase
        end
    end

endmodule

//--- rtl/frame_sync.sv
`timescale 1ns/10ps

module frame_sync import xgpon_pkg::*; (
    input  logic      axis_clk,
    input  logic      rst,

    input  pon_word_t pon_rx,

    output eth_word_t eth_out,
    output logic      eth_out_valid
);

    localparam int ERR_W = $clog2(DATA_W + 1);

    sync_state_e       state;
    logic [LEN_W-1:0]  remain;     // payload words still to come
    logic [KEEP_W-1:0] last_keep;  // from header
    logic [DATA_W-1:0] diff;
    logic [ERR_W-1:0]  sync_errs;
    logic              sync_hit;
    logic              hdr_ok;
    pon_hdr_t          hdr;

    ////////////////////
    // sync correlator
    ////////////////////
    assign diff      = pon_rx.data ^ SYNC_WORD;
    assign sync_errs = ERR_W'($countones(diff));   // bit errors vs sync
    assign sync_hit  = pon_rx.burst_en && (sync_errs <= ERR_W'(SYNC_THRESHOLD));

    // header check, length must fit a frame
    assign hdr    = pon_hdr_t'(pon_rx.data);
    assign hdr_ok = pon_rx.burst_en &&
                    (hdr.magic == HDR_MAGIC) &&
                    (hdr.len != '0) &&
                    (hdr.len <= 12'(MAX_FRAME_WORDS));

    always_ff @(posedge axis_clk) begin
        if (rst) begin
            state         <= FS_HUNT;
            remain        <= '0;
            eth_out_valid <= 1'b0;
        end else begin
            eth_out_valid <= 1'b0;
            case (state)
                FS_HUNT: begin
                    if (sync_hit) begin
                        state <= FS_HEADER;
                    end
                end
                FS_HEADER: begin
                    if (hdr_ok) begin
                        remain <= LEN_W'(hdr.len);
                        state  <= FS_PAYLOAD;
                    end else begin
                        state <= FS_HUNT;  // false sync or corrupt header
                    end
                end
                FS_PAYLOAD: begin
                    if (!pon_rx.burst_en) begin
                        // burst cut short, back to hunting
                        state <= FS_HUNT;
                    end else begin
                        eth_out_valid <= 1'b1;
                        remain        <= remain - 1'b1;
                        if (remain == LEN_W'(1)) begin
                            state <= FS_HUNT;
                        end
                    end
                end
                default: state <= FS_HUNT;
            endcase
        end
    end

    ////////////////////
    // output word and header keep
    ////////////////////
    always_ff @(posedge axis_clk) begin
        if (state == FS_HEADER) begin
            last_keep <= hdr.keep;
        end
        // registered, one cycle after the line word
        eth_out.data <= pon_rx.data;
        eth_out.last <= (remain == LEN_W'(1));
        eth_out.keep <= (remain == LEN_W'(1)) ? last_keep : '1;  // full except last
    end

endmodule

//--- rtl/xgpon_bridge.sv
`timescale 1ns/10ps

module xgpon_bridge import xgpon_pkg::*; (
    input  logic      axis_clk,
    input  logic      rst,

    // ethernet in, upstream burst out
    input  eth_word_t eth_in,
    input  logic      eth_in_valid,
    output logic      eth_in_ready,
    output pon_word_t pon_tx,

    // pon in, ethernet out (no stall)
    input  pon_word_t pon_rx,
    output eth_word_t eth_out,
    output logic      eth_out_valid
);

    eth_word_t   wr_word;
    logic        wr_en;
    logic        wr_commit;
    logic        wr_abort;
    frame_desc_t wr_desc;
    logic        wr_space;

    logic        rd_desc_valid;
    frame_desc_t rd_desc;
    logic        rd_desc_pop;
    logic        rd_en;
    eth_word_t   rd_word;

    ////////////////////
    // transmit path
    ////////////////////
    eth_ingress i_eth_ingress (
        .axis_clk     (axis_clk),
        .rst          (rst),
        .eth_in       (eth_in),
        .eth_in_valid (eth_in_valid),
        .eth_in_ready (eth_in_ready),
        .wr_word      (wr_word),
        .wr_en        (wr_en),
        .wr_commit    (wr_commit),
        .wr_abort     (wr_abort),
        .wr_desc      (wr_desc),
        .wr_space     (wr_space)
    );

    frame_fifo i_frame_fifo (
        .axis_clk      (axis_clk),
        .rst           (rst),
        .wr_word       (wr_word),
        .wr_en         (wr_en),
        .wr_commit     (wr_commit),
        .wr_abort      (wr_abort),
        .wr_desc       (wr_desc),
        .wr_space      (wr_space),
        .rd_desc_valid (rd_desc_valid),
        .rd_desc       (rd_desc),
        .rd_desc_pop   (rd_desc_pop),
        .rd_en         (rd_en),
        .rd_word       (rd_word)
    );

    burst_tx i_burst_tx (
        .axis_clk      (axis_clk),
        .rst           (rst),
        .rd_desc_valid (rd_desc_valid),
        .rd_desc       (rd_desc),
        .rd_desc_pop   (rd_desc_pop),
        .rd_en         (rd_en),
        .rd_word       (rd_word),
        .pon_tx        (pon_tx)
    );

    ////////////////////
    // receive path
    ////////////////////
    frame_sync i_frame_sync (
        .axis_clk      (axis_clk),
        .rst           (rst),
        .pon_rx        (pon_rx),
        .eth_out       (eth_out),
        .eth_out_valid (eth_out_valid)
    );

endmodule

//--- bench/xgpon_bridge_properties.sv
`timescale 1ns/10ps

module xgpon_bridge_properties import xgpon_pkg::*; (
    input logic      axis_clk,
    input logic      rst,
    input eth_word_t eth_in,
    input logic      eth_in_valid,
    input logic      eth_in_ready,
    input pon_word_t pon_tx,
    input logic      eth_out_valid
);

    logic [7:0] low_run;  // idle line cycles since last burst word

    always_ff @(posedge axis_clk) begin
        if (rst) begin
            low_run <= 8'(GUARD_WORDS);  // line is quiet out of reset
        end else if (pon_tx.burst_en) begin
            low_run <= '0;
        end else if (low_run != 8'hFF) begin
            low_run <= low_run + 1'b1;   // saturates
        end
    end

    ////////////////////
    // line and stream rules
    ////////////////////
    a_guard_gap: assert property (@(posedge axis_clk) disable iff (rst)
        $rose(pon_tx.burst_en) |-> low_run >= 8'(GUARD_WORDS))
        else $error("burst started inside the guard gap");

    a_quiet_in_reset: assert property (@(posedge axis_clk)
        rst |=> !eth_out_valid)
        else $error("eth_out_valid high during reset");

    // source holds its word until taken
    a_input_hold: assert property (@(posedge axis_clk) disable iff (rst)
        eth_in_valid && !eth_in_ready |=> eth_in_valid && $stable(eth_in))
        else $error("eth_in changed while stalled");

endmodule

bind xgpon_bridge xgpon_bridge_properties i_xgpon_bridge_properties (
    .axis_clk      (axis_clk),
    .rst           (rst),
    .eth_in        (eth_in),
    .eth_in_valid  (eth_in_valid),
    .eth_in_ready  (eth_in_ready),
    .pon_tx        (pon_tx),
    .eth_out_valid (eth_out_valid)
);

//--- bench/tb_xgpon_bridge.sv
`timescale 1ns/10ps

module tb_xgpon_bridge import xgpon_pkg::*; ();

    // frame words and bursts over all tests (the oversize frame sends no burst)
    localparam int TEST_WORDS      = 1 + 7 + 32 + 8 * MAX_FRAME_WORDS + 9 + 40 + 5 + 6 + 12;
    localparam int TEST_BURSTS     = 16;
    localparam int BURST_OVERHEAD  = PREAMBLE_WORDS + 2 + GUARD_WORDS + 1;
    localparam int WATCHDOG_CYCLES = 4 * (TEST_WORDS + TEST_BURSTS * BURST_OVERHEAD) + 10;

    logic              axis_clk;
    logic              rst;
    eth_word_t         eth_in;
    logic              eth_in_valid;
    logic              eth_in_ready;
    pon_word_t         pon_tx;
    pon_word_t         pon_rx;
    eth_word_t         eth_out;
    logic              eth_out_valid;

    logic [DATA_W-1:0] flip_mask;     // bits flipped on the sync word
    logic [DATA_W-1:0] inject;
    logic [31:0]       rng;
    int                burst_pos;     // burst words seen before this cycle
    int                cur_len;
    int                bursts_queued;
    int                bursts_done;
    logic [7:0]        exp_seq;
    logic              ready_dropped;
    string             test_name;
    eth_word_t         exp_q[$];      // words that must come out
    int                len_q[$];      // lengths of frames that go on the line

    xgpon_bridge i_xgpon_bridge (
        .axis_clk      (axis_clk),
        .rst           (rst),
        .eth_in        (eth_in),
        .eth_in_valid  (eth_in_valid),
        .eth_in_ready  (eth_in_ready),
        .pon_tx        (pon_tx),
        .pon_rx        (pon_rx),
        .eth_out       (eth_out),
        .eth_out_valid (eth_out_valid)
    );

    always #20 axis_clk = ~axis_clk;

    ////////////////////
    // loopback
    ////////////////////
    assign inject = (pon_tx.burst_en && burst_pos == PREAMBLE_WORDS) ? flip_mask : '0;
    assign pon_rx.burst_en = rst ? 1'b0 : pon_tx.burst_en;
    assign pon_rx.data     = rst ? '0 : (pon_tx.data ^ inject);

    always @(posedge axis_clk) begin
        if (rst || !pon_tx.burst_en) begin
            burst_pos <= 0;
        end else begin
            burst_pos <= burst_pos + 1;
        end
    end

    always @(negedge axis_clk) begin
        if (!rst && !eth_in_ready) begin
            ready_dropped = 1'b1;  // back-pressure seen
        end
    end

    ////////////////////
    // helpers
    ////////////////////
    task automatic stop_with_error(input string msg);
        $display("Error in %s: %s", test_name, msg);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("Mismatch in %s: %s expected %h, actual %h", test_name, what, exp, act);
        $display("Result: FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // random payload kept too far from sync to fool the hunt
    task automatic pick_data(output logic [DATA_W-1:0] d);
        rng = xorshift32(rng);
        while ($countones(rng ^ SYNC_WORD) <= SYNC_THRESHOLD) begin
            rng = xorshift32(rng);
        end
        d = rng;
    endtask

    task automatic drive_word(input eth_word_t w);
        logic taken;
        eth_in       = w;
        eth_in_valid = 1'b1;
        do begin
            taken = eth_in_ready;  // steady until the next edge
            @(posedge axis_clk);
            #1;
        end while (!taken);
    endtask

    task automatic send_frame(input int len, input logic [KEEP_W-1:0] last_keep,
                              input bit arrives);
        eth_word_t         w;
        logic [DATA_W-1:0] d;
        int                i;
        if (len <= MAX_FRAME_WORDS) begin
            len_q.push_back(len);       // oversize frames never reach the line
            bursts_queued++;
        end
        for (i = 0; i < len; i++) begin
            pick_data(d);
            w.data = d;
            w.last = (i == len - 1);
            w.keep = w.last ? last_keep : '1;
            if (arrives && len <= MAX_FRAME_WORDS) exp_q.push_back(w);
            drive_word(w);
        end
    endtask

    // until every expected word is out and every burst is checked
    task automatic wait_drain();
        eth_in_valid = 1'b0;
        while (exp_q.size() != 0 || bursts_done != bursts_queued) @(posedge axis_clk);
        @(posedge axis_clk);
        #1;
    endtask

    ////////////////////
    // monitors
    ////////////////////
    always @(negedge axis_clk) begin
        eth_word_t exp_w;
        if (!rst && eth_out_valid) begin
            assert (exp_q.size() != 0)
                else stop_with_error("output word with no frame expected");
            exp_w = exp_q.pop_front();
            assert (eth_out == exp_w) else report_mismatch("eth_out", 64'(exp_w), 64'(eth_out));
        end
    end

    always @(negedge axis_clk) begin
        pon_hdr_t hdr;
        hdr = pon_tx.data;
        if (!rst && pon_tx.burst_en) begin
            if (burst_pos < PREAMBLE_WORDS) begin
                assert (pon_tx.data == PREAMBLE_PATTERN)
                    else report_mismatch("preamble", 64'(PREAMBLE_PATTERN), 64'(pon_tx.data));
            end else if (burst_pos == PREAMBLE_WORDS) begin
                assert (pon_tx.data == SYNC_WORD)
                    else report_mismatch("sync", 64'(SYNC_WORD), 64'(pon_tx.data));
            end else if (burst_pos == PREAMBLE_WORDS + 1) begin
                assert (len_q.size() != 0) else stop_with_error("burst with no frame queued");
                cur_len = len_q.pop_front();
                assert (hdr.magic == HDR_MAGIC)
                    else report_mismatch("header magic", 64'(HDR_MAGIC), 64'(hdr.magic));
                assert (hdr.seq == exp_seq)
                    else report_mismatch("header seq", 64'(exp_seq), 64'(hdr.seq));
                assert (hdr.len == 12'(cur_len))
                    else report_mismatch("header len", 64'(cur_len), 64'(hdr.len));
                exp_seq = exp_seq + 8'd1;
            end
        end else if (!rst && burst_pos != 0) begin
            // burst_pos holds the burst length in the first idle cycle
            assert (burst_pos == PREAMBLE_WORDS + 2 + cur_len)
                else report_mismatch("burst length", 64'(PREAMBLE_WORDS + 2 + cur_len),
                                     64'(burst_pos));
            bursts_done++;
        end
    end

    ////////////////////
    // tests
    ////////////////////
    task automatic single_frames();
        test_name = "single_frames";
        send_frame(1, 4'b0001, 1);
        send_frame(7, 4'b0111, 1);
        send_frame(32, 4'b1111, 1);
        wait_drain();
    endtask

    task automatic back_to_back();
        int                i;
        int                len;
        logic [KEEP_W-1:0] k;
        test_name     = "back_to_back";
        ready_dropped = 1'b0;
        for (i = 0; i < 8; i++) begin
            rng = xorshift32(rng);
            len = 1 + int'(rng % 8);  // short frames queue up faster than bursts drain
            k   = rng[KEEP_W+7:8];
            if (k == '0) k = 4'b0001;
            send_frame(len, k, 1);  // no idle between frames
        end
        wait_drain();
        assert (ready_dropped)
            else stop_with_error("eth_in_ready never dropped as the FIFO filled");
        assert (eth_in_ready)
            else stop_with_error("eth_in_ready stayed low after the FIFO drained");
    endtask

    task automatic oversize_frame();
        test_name = "oversize_frame";
        send_frame(9, 4'b0011, 1);
        send_frame(40, 4'b1111, 0);  // dropped in ingress
        send_frame(5, 4'b0001, 1);
        wait_drain();
    endtask

    task automatic sync_within_threshold();
        test_name = "sync_within_threshold";
        flip_mask = DATA_W'((1 << SYNC_THRESHOLD) - 1);
        send_frame(6, 4'b0111, 1);
        wait_drain();
        flip_mask = '0;
    endtask

    task automatic sync_beyond_threshold();
        test_name = "sync_beyond_threshold";
        flip_mask = DATA_W'((1 << (SYNC_THRESHOLD + 1)) - 1);
        send_frame(6, 4'b0011, 0);   // sync missed so the frame is lost
        wait_drain();
        flip_mask = '0;
        send_frame(6, 4'b1111, 1);
        wait_drain();
    endtask

    // hang guard
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge axis_clk);
        stop_with_error("watchdog expired before all tests finished");
    end

    initial begin
        axis_clk      = 1'b0;
        rst           = 1'b1;
        eth_in        = '0;
        eth_in_valid  = 1'b0;
        flip_mask     = '0;
        rng           = 32'd45000;
        cur_len       = 0;
        bursts_queued = 0;
        bursts_done   = 0;
        exp_seq       = '0;
        ready_dropped = 1'b0;
        test_name     = "reset";
        repeat (3) @(posedge axis_clk);
        #1;
        rst = 1'b0;
        single_frames();
        back_to_back();
        oversize_frame();
        sync_within_threshold();
        sync_beyond_threshold();
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- xgpon_bridge.f
rtl/xgpon_pkg.sv
rtl/eth_ingress.sv
rtl/frame_fifo.sv
rtl/burst_tx.sv
rtl/frame_sync.sv
rtl/xgpon_bridge.sv
bench/xgpon_bridge_properties.sv
bench/tb_xgpon_bridge.sv

//--- run.sh
#!/bin/sh
# build and run the bridge testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f xgpon_bridge.f \
    --top-module tb_xgpon_bridge \
    -o sim_xgpon_bridge &&
    ./obj_dir/sim_xgpon_bridge | tee /dev/stderr | grep -q "Result: PASSED" &&
    exit 0 || exit 1
